// File: source/rvc_pkg.sv
// rvc decoder shared definitions
// widths, register numbers, unit and micro-op encodings, stage records
package rvc_pkg;

    localparam int INSTR_BITS  = 16;
    localparam int PC_BITS     = 32;
    localparam int XLEN        = 32;
    // bit 5 of a register id selects the float file
    localparam int REG_ID_BITS = 6;

    localparam logic [4:0] SP_REG = 5'd2;
    localparam logic [4:0] RA_REG = 5'd1;

    typedef enum logic [1:0] {
        FU_LSU    = 2'd0,
        FU_FPU    = 2'd1,
        FU_INT    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_t;

    // load shares its code with sub, the unit tells them apart
    typedef enum logic [4:0] {
        UOP_ADD      = 5'd0,
        UOP_SUB_LOAD = 5'd1,
        UOP_STORE    = 5'd6,
        UOP_SLL      = 5'd7,
        UOP_SRL      = 5'd8,
        UOP_SRA      = 5'd9,
        UOP_AND      = 5'd10,
        UOP_OR       = 5'd11,
        UOP_XOR      = 5'd12,
        UOP_JUMP_REG = 5'd18,
        UOP_JUMP     = 5'd19,
        UOP_BEQ      = 5'd20,
        UOP_BNE      = 5'd21
    } uop_t;

    // compressed immediate layouts
    typedef enum logic [3:0] {
        IMM_NONE,
        IMM_ADDI4SPN,
        IMM_LSW,
        IMM_CI_S,
        IMM_CI_U,
        IMM_ADDI16SP,
        IMM_LUI,
        IMM_CJ,
        IMM_CB,
        IMM_LWSP,
        IMM_SWSP
    } imm_fmt_t;

    typedef struct packed {
        logic [PC_BITS-1:0]    pc;
        logic [INSTR_BITS-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic [PC_BITS-1:0]     pc;
        logic [REG_ID_BITS-1:0] source1;
        logic                   source1_pc;
        logic [REG_ID_BITS-1:0] source2;
        logic                   source2_immediate;
        logic [REG_ID_BITS-1:0] destination;
        logic [XLEN-1:0]        immediate;
        fu_t                    functional_unit;
        uop_t                   microoperation;
        logic                   is_branch;
        logic                   is_return;
        logic                   is_valid;
    } decoded_t;

endpackage

// File: source/rvc_fetch_reg.sv
`timescale 1ns/1ns
// rvc fetch register
// one-entry holding stage in front of the decode logic
module rvc_fetch_reg (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  rvc_pkg::fetch_t in_data,
    output logic            in_ready,
    output logic            fetch_valid,
    output rvc_pkg::fetch_t fetch_data,
    input  logic            take
);

    // free slot, or the held item moves on this edge
    assign in_ready = ~fetch_valid | take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_valid <= 1'b0;
        end else if (in_ready) begin
            fetch_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            fetch_data <= in_data;
        end
    end

endmodule

// File: source/rvc_op_decode.sv
`timescale 1ns/1ns
// rvc operation decode
// maps a compressed instruction to operands, unit, micro-op and immediate layout
module rvc_op_decode (
    input  logic [rvc_pkg::INSTR_BITS-1:0] instr,
    input  logic [rvc_pkg::PC_BITS-1:0]    pc,
    output rvc_pkg::decoded_t              decoded,
    output rvc_pkg::imm_fmt_t              imm_fmt
);
    import rvc_pkg::*;

    logic [1:0] quadrant;
    logic [2:0] funct3;
    logic [4:0] rs1_rd;
    logic [4:0] rs2;
    logic [2:0] rs1c;
    logic [2:0] rs2c;

    // compressed ids cover x8..x15 or f8..f15
    function automatic logic [REG_ID_BITS-1:0] creg(input logic [2:0] idx, input logic fp);
        creg = {fp, 2'b01, idx};
    endfunction

    function automatic logic [REG_ID_BITS-1:0] xreg(input logic [4:0] idx, input logic fp);
        xreg = {fp, idx};
    endfunction

    assign quadrant = instr[1:0];
    assign funct3   = instr[15:13];
    assign rs1_rd   = instr[11:7];
    assign rs2      = instr[6:2];
    assign rs1c     = instr[9:7];
    assign rs2c     = instr[4:2];

    always_comb begin
        decoded                 = '0;
        decoded.pc              = pc;
        decoded.functional_unit = FU_INT;
        decoded.microoperation  = UOP_ADD;
        decoded.is_valid        = 1'b1;
        imm_fmt                 = IMM_NONE;
        case (quadrant)
            2'b00: begin
                decoded.source1 = creg(rs1c, 1'b0);
                case (funct3)
                    3'b000: begin
                        // addi4spn
                        decoded.source1           = xreg(SP_REG, 1'b0);
                        decoded.source2_immediate = 1'b1;
                        decoded.destination       = creg(rs2c, 1'b0);
                        imm_fmt                   = IMM_ADDI4SPN;
                    end
                    3'b010, 3'b011: begin
                        // lw, flw
                        decoded.source2_immediate = 1'b1;
                        decoded.destination       = creg(rs2c, funct3[0]);
                        decoded.functional_unit   = FU_LSU;
                        decoded.microoperation    = UOP_SUB_LOAD;
                        imm_fmt                   = IMM_LSW;
                    end
                    3'b110, 3'b111: begin
                        // sw, fsw
                        decoded.source2         = creg(rs2c, funct3[0]);
                        decoded.functional_unit = FU_LSU;
                        decoded.microoperation  = UOP_STORE;
                        imm_fmt                 = IMM_LSW;
                    end
                    default: decoded.is_valid = 1'b0;
                endcase
            end
            2'b01: begin
                decoded.source2_immediate = 1'b1;
                case (funct3)
                    3'b000: begin
                        decoded.source1     = xreg(rs1_rd, 1'b0);
                        decoded.destination = xreg(rs1_rd, 1'b0);
                        imm_fmt             = IMM_CI_S;
                    end
                    3'b010: begin
                        // li adds to x0
                        decoded.destination = xreg(rs1_rd, 1'b0);
                        imm_fmt             = IMM_CI_S;
                    end
                    3'b011: begin
                        decoded.destination = xreg(rs1_rd, 1'b0);
                        if ({instr[12], instr[6:2]} == 6'd0) begin
                            decoded.is_valid = 1'b0;
                        end else if (rs1_rd == SP_REG) begin
                            decoded.source1 = xreg(SP_REG, 1'b0);
                            imm_fmt         = IMM_ADDI16SP;
                        end else begin
                            imm_fmt = IMM_LUI;
                        end
                    end
                    3'b100: begin
                        decoded.source1     = creg(rs1c, 1'b0);
                        decoded.destination = creg(rs1c, 1'b0);
                        case (instr[11:10])
                            2'b00: begin
                                decoded.microoperation = UOP_SRL;
                                imm_fmt                = IMM_CI_U;
                            end
                            2'b01: begin
                                decoded.microoperation = UOP_SRA;
                                imm_fmt                = IMM_CI_U;
                            end
                            2'b10: begin
                                decoded.microoperation = UOP_AND;
                                imm_fmt                = IMM_CI_S;
                            end
                            default: begin
                                // register-register alu group
                                decoded.source2           = creg(rs2c, 1'b0);
                                decoded.source2_immediate = 1'b0;
                                case (instr[6:5])
                                    2'b00:   decoded.microoperation = UOP_SUB_LOAD;
                                    2'b01:   decoded.microoperation = UOP_XOR;
                                    2'b10:   decoded.microoperation = UOP_OR;
                                    default: decoded.microoperation = UOP_AND;
                                endcase
                            end
                        endcase
                    end
                    3'b001, 3'b101: begin
                        // jal links to ra, j does not
                        decoded.source1_pc      = 1'b1;
                        decoded.destination     = funct3[2] ? '0 : xreg(RA_REG, 1'b0);
                        decoded.functional_unit = FU_BRANCH;
                        decoded.microoperation  = UOP_JUMP;
                        decoded.is_branch       = 1'b1;
                        imm_fmt                 = IMM_CJ;
                    end
                    default: begin
                        // beqz, bnez against x0
                        decoded.source1           = creg(rs1c, 1'b0);
                        decoded.source2_immediate = 1'b0;
                        decoded.functional_unit   = FU_BRANCH;
                        decoded.microoperation    = funct3[0] ? UOP_BNE : UOP_BEQ;
                        decoded.is_branch         = 1'b1;
                        imm_fmt                   = IMM_CB;
                    end
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: begin
                        decoded.source1           = xreg(rs1_rd, 1'b0);
                        decoded.source2_immediate = 1'b1;
                        decoded.destination       = xreg(rs1_rd, 1'b0);
                        decoded.microoperation    = UOP_SLL;
                        imm_fmt                   = IMM_CI_U;
                    end
                    3'b010, 3'b011: begin
                        // lwsp, flwsp
                        decoded.source1           = xreg(SP_REG, 1'b0);
                        decoded.source2_immediate = 1'b1;
                        decoded.destination       = xreg(rs1_rd, funct3[0]);
                        decoded.functional_unit   = FU_LSU;
                        decoded.microoperation    = UOP_SUB_LOAD;
                        imm_fmt                   = IMM_LWSP;
                    end
                    3'b100: begin
                        if (rs2 != 5'd0) begin
                            // mv reads x0 as source1, add reads rd
                            decoded.source1     = instr[12] ? xreg(rs1_rd, 1'b0) : '0;
                            decoded.source2     = xreg(rs2, 1'b0);
                            decoded.destination = xreg(rs1_rd, 1'b0);
                            decoded.is_valid    = ~(instr[12] && rs1_rd == 5'd0);
                        end else if (instr[12] && rs1_rd == 5'd0) begin
                            // ebreak
                            decoded.is_valid = 1'b0;
                        end else begin
                            // jr, jalr
                            decoded.source1         = xreg(rs1_rd, 1'b0);
                            decoded.destination     = instr[12] ? xreg(RA_REG, 1'b0) : '0;
                            decoded.functional_unit = FU_BRANCH;
                            decoded.microoperation  = UOP_JUMP_REG;
                            decoded.is_branch       = 1'b1;
                            decoded.is_return       = ~instr[12] && (rs1_rd == RA_REG);
                        end
                    end
                    3'b110, 3'b111: begin
                        // swsp, fswsp
                        decoded.source1         = xreg(SP_REG, 1'b0);
                        decoded.source2         = xreg(rs2, funct3[0]);
                        decoded.functional_unit = FU_LSU;
                        decoded.microoperation  = UOP_STORE;
                        imm_fmt                 = IMM_SWSP;
                    end
                    default: decoded.is_valid = 1'b0;
                endcase
            end
            default: decoded.is_valid = 1'b0;
        endcase
        // unknown encodings keep only the pc
        if (!decoded.is_valid) begin
            decoded    = '0;
            decoded.pc = pc;
            imm_fmt    = IMM_NONE;
        end
    end

endmodule

// File: source/rvc_imm_gen.sv
`timescale 1ns/1ns
// rvc immediate generator
// rebuilds the 32-bit immediate from the scattered compressed fields
module rvc_imm_gen (
    input  logic [rvc_pkg::INSTR_BITS-1:0] instr,
    input  rvc_pkg::imm_fmt_t              imm_fmt,
    output logic [rvc_pkg::XLEN-1:0]       imm
);
    import rvc_pkg::*;

    logic sign;

    assign sign = instr[12];

    always_comb begin
        case (imm_fmt)
            IMM_ADDI4SPN: begin
                imm = {{(XLEN-10){1'b0}}, instr[10:7], instr[12:11], instr[5], instr[6], 2'b00};
            end
            IMM_LSW: begin
                imm = {{(XLEN-7){1'b0}}, instr[5], instr[12:10], instr[6], 2'b00};
            end
            IMM_CI_S: begin
                imm = {{(XLEN-6){sign}}, sign, instr[6:2]};
            end
            // shift amounts are unsigned
            IMM_CI_U: begin
                imm = {{(XLEN-6){1'b0}}, instr[12], instr[6:2]};
            end
            IMM_ADDI16SP: begin
                imm = {{(XLEN-10){sign}}, sign, instr[4:3], instr[5], instr[2], instr[6], 4'b0000};
            end
            IMM_LUI: begin
                imm = {{(XLEN-18){sign}}, sign, instr[6:2], 12'h000};
            end
            IMM_CJ: begin
                imm = {{(XLEN-12){sign}}, sign, instr[8], instr[10:9], instr[6], instr[7],
                       instr[2], instr[11], instr[5:3], 1'b0};
            end
            IMM_CB: begin
                imm = {{(XLEN-9){sign}}, sign, instr[6:5], instr[2], instr[11:10],
                       instr[4:3], 1'b0};
            end
            IMM_LWSP: begin
                imm = {{(XLEN-8){1'b0}}, instr[3:2], instr[12], instr[6:4], 2'b00};
            end
            IMM_SWSP: begin
                imm = {{(XLEN-8){1'b0}}, instr[8:7], instr[12:9], 2'b00};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: source/rvc_issue_reg.sv
`timescale 1ns/1ns
// rvc issue register
// holds one decoded record until the consumer takes it
module rvc_issue_reg (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  rvc_pkg::decoded_t dec_data,
    output logic              take,
    output logic              out_valid,
    output rvc_pkg::decoded_t out_data,
    input  logic              out_ready
);

    // empty, or the current record leaves this edge
    assign take = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take && dec_valid) begin
            out_data <= dec_data;
        end
    end

endmodule

// File: source/rvc_decoder_top.sv
`timescale 1ns/1ns
// rvc decoder top level
// fetch register, decode and immediate logic, issue register
module rvc_decoder_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  rvc_pkg::fetch_t   in_data,
    output logic              in_ready,
    output logic              out_valid,
    output rvc_pkg::decoded_t out_data,
    input  logic              out_ready
);
    import rvc_pkg::*;

    logic            fetch_valid;
    fetch_t          fetch_data;
    logic            take;
    decoded_t        dec_raw;
    decoded_t        dec_full;
    imm_fmt_t        imm_fmt;
    logic [XLEN-1:0] imm;

    rvc_fetch_reg u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .take        (take)
    );

    rvc_op_decode u_decode (
        .instr   (fetch_data.instr),
        .pc      (fetch_data.pc),
        .decoded (dec_raw),
        .imm_fmt (imm_fmt)
    );

    rvc_imm_gen u_imm (
        .instr   (fetch_data.instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // drop the generated immediate into the record
    always_comb begin
        dec_full           = dec_raw;
        dec_full.immediate = imm;
    end

    rvc_issue_reg u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (fetch_valid),
        .dec_data  (dec_full),
        .take      (take),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

// File: testbench/rvc_decoder_props.sv
`timescale 1ns/1ns
// stream handshake properties of the rvc decoder top level
module rvc_decoder_props (
    input logic              clk,
    input logic              arst_n,
    input logic              in_ready,
    input logic              out_valid,
    input logic              out_ready,
    input rvc_pkg::decoded_t out_data
);

    // a stalled record must hold until taken
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("out_data changed while stalled");

    assert property (@(posedge clk) $rose(arst_n) |-> !out_valid && in_ready)
        else $error("outputs not idle right after reset");

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out_data.is_valid || !out_data.is_branch)
        else $error("branch flag on an invalid record");

endmodule

bind rvc_decoder_top rvc_decoder_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: testbench/rvc_ref_model.svh
// reference decode for the rvc decoder testbench
// builds the expected record from the compressed encoding tables
decoded_t expected_q[$];

// low w bits of v hold a two's complement value
function automatic logic [31:0] sign_extend(input logic [31:0] v, input int w);
    sign_extend = (v ^ (32'd1 << (w - 1))) - (32'd1 << (w - 1));
endfunction

function automatic decoded_t decode_ref(input logic [31:0] pc, input logic [15:0] ins);
    decoded_t    d;
    logic [31:0] imm;
    logic [5:0]  rd;
    logic [5:0]  rdp;
    logic [5:0]  rs1p;
    logic        ok;
    d    = '0;
    imm  = '0;
    ok   = 1'b1;
    rd   = {1'b0, ins[11:7]};
    rdp  = {ins[13], 2'b01, ins[4:2]};
    rs1p = {1'b0, 2'b01, ins[9:7]};
    d.functional_unit = FU_INT;
    d.microoperation  = UOP_ADD;
    case ({ins[1:0], ins[15:13]})
        5'b00_000: begin
            d.source1           = 6'd2;
            d.source2_immediate = 1'b1;
            d.destination       = {1'b0, rdp[4:0]};
            imm = 32'({ins[10:7], ins[12:11], ins[5], ins[6], 2'b00});
        end
        5'b00_010, 5'b00_011: begin
            d.source1           = rs1p;
            d.source2_immediate = 1'b1;
            d.destination       = rdp;
            d.functional_unit   = FU_LSU;
            d.microoperation    = UOP_SUB_LOAD;
            imm = 32'({ins[5], ins[12:10], ins[6], 2'b00});
        end
        5'b00_110, 5'b00_111: begin
            d.source1         = rs1p;
            d.source2         = rdp;
            d.functional_unit = FU_LSU;
            d.microoperation  = UOP_STORE;
            imm = 32'({ins[5], ins[12:10], ins[6], 2'b00});
        end
        5'b01_000, 5'b01_010: begin
            // li has x0 as source1
            d.source1           = ins[14] ? 6'd0 : rd;
            d.source2_immediate = 1'b1;
            d.destination       = rd;
            imm = sign_extend(32'({ins[12], ins[6:2]}), 6);
        end
        5'b01_011: begin
            d.source2_immediate = 1'b1;
            d.destination       = rd;
            if ({ins[12], ins[6:2]} == 6'd0) begin
                ok = 1'b0;
            end else if (rd == 6'd2) begin
                d.source1 = 6'd2;
                imm = sign_extend(32'({ins[12], ins[4:3], ins[5], ins[2], ins[6], 4'b0}), 10);
            end else begin
                imm = sign_extend(32'({ins[12], ins[6:2], 12'h000}), 18);
            end
        end
        5'b01_100: begin
            d.source1           = rs1p;
            d.destination       = rs1p;
            d.source2_immediate = 1'b1;
            case (ins[11:10])
                2'b00: d.microoperation = UOP_SRL;
                2'b01: d.microoperation = UOP_SRA;
                default: d.microoperation = UOP_AND;
            endcase
            if (ins[11:10] == 2'b10) begin
                imm = sign_extend(32'({ins[12], ins[6:2]}), 6);
            end else if (ins[11:10] != 2'b11) begin
                imm = 32'({ins[12], ins[6:2]});
            end else begin
                d.source2_immediate = 1'b0;
                d.source2           = {1'b0, 2'b01, ins[4:2]};
                case (ins[6:5])
                    2'b00: d.microoperation = UOP_SUB_LOAD;
                    2'b01: d.microoperation = UOP_XOR;
                    2'b10: d.microoperation = UOP_OR;
                    default: d.microoperation = UOP_AND;
                endcase
            end
        end
        5'b01_001, 5'b01_101: begin
            d.source1_pc        = 1'b1;
            d.source2_immediate = 1'b1;
            d.destination       = ins[15] ? 6'd0 : 6'd1;
            d.functional_unit   = FU_BRANCH;
            d.microoperation    = UOP_JUMP;
            d.is_branch         = 1'b1;
            imm = sign_extend(32'({ins[12], ins[8], ins[10:9], ins[6], ins[7], ins[2],
                                   ins[11], ins[5:3], 1'b0}), 12);
        end
        5'b01_110, 5'b01_111: begin
            d.source1         = rs1p;
            d.functional_unit = FU_BRANCH;
            d.microoperation  = ins[13] ? UOP_BNE : UOP_BEQ;
            d.is_branch       = 1'b1;
            imm = sign_extend(32'({ins[12], ins[6:5], ins[2], ins[11:10], ins[4:3], 1'b0}), 9);
        end
        5'b10_000: begin
            d.source1           = rd;
            d.source2_immediate = 1'b1;
            d.destination       = rd;
            d.microoperation    = UOP_SLL;
            imm = 32'({ins[12], ins[6:2]});
        end
        5'b10_010, 5'b10_011: begin
            d.source1           = 6'd2;
            d.source2_immediate = 1'b1;
            d.destination       = {ins[13], ins[11:7]};
            d.functional_unit   = FU_LSU;
            d.microoperation    = UOP_SUB_LOAD;
            imm = 32'({ins[3:2], ins[12], ins[6:4], 2'b00});
        end
        5'b10_100: begin
            if (ins[12] && rd == 6'd0) begin
                ok = 1'b0;
            end else if (ins[6:2] != 5'd0) begin
                d.source1     = ins[12] ? rd : 6'd0;
                d.source2     = {1'b0, ins[6:2]};
                d.destination = rd;
            end else begin
                d.source1         = rd;
                d.destination     = ins[12] ? 6'd1 : 6'd0;
                d.functional_unit = FU_BRANCH;
                d.microoperation  = UOP_JUMP_REG;
                d.is_branch       = 1'b1;
                d.is_return       = !ins[12] && rd == 6'd1;
            end
        end
        5'b10_110, 5'b10_111: begin
            d.source1         = 6'd2;
            d.source2         = {ins[13], ins[6:2]};
            d.functional_unit = FU_LSU;
            d.microoperation  = UOP_STORE;
            imm = 32'({ins[8:7], ins[12:9], 2'b00});
        end
        default: ok = 1'b0;
    endcase
    d.immediate = imm;
    d.is_valid  = ok;
    if (!ok) begin
        d = '0;
    end
    d.pc = pc;
    return d;
endfunction

function automatic void expect_record(input logic [31:0] pc, input logic [15:0] ins);
    expected_q.push_back(decode_ref(pc, ins));
endfunction

// File: testbench/tb_rvc_decoder.sv
`timescale 1ns/1ns
// rvc decoder testbench
// random and directed instruction streams checked against a reference decode
module tb_rvc_decoder;
    import rvc_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    fetch_t      in_data;
    logic        in_ready;
    logic        out_valid;
    decoded_t    out_data;
    logic        out_ready;
    logic        ready_high;
    logic        streaming;
    bit          stream_seen = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          in_cnt = 0;
    int          out_cnt = 0;
    logic [31:0] pc_next = 32'h0000_1000;

    `include "rvc_ref_model.svh"

    rvc_decoder_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_record(input decoded_t got, input decoded_t exp);
        check_value("pc", 128'(got.pc), 128'(exp.pc));
        check_value("source1", 128'(got.source1), 128'(exp.source1));
        check_value("source1_pc", 128'(got.source1_pc), 128'(exp.source1_pc));
        check_value("source2", 128'(got.source2), 128'(exp.source2));
        check_value("source2_immediate", 128'(got.source2_immediate),
                    128'(exp.source2_immediate));
        check_value("destination", 128'(got.destination), 128'(exp.destination));
        check_value("immediate", 128'(got.immediate), 128'(exp.immediate));
        check_value("functional_unit", 128'(got.functional_unit), 128'(exp.functional_unit));
        check_value("microoperation", 128'(got.microoperation), 128'(exp.microoperation));
        check_value("is_branch", 128'(got.is_branch), 128'(exp.is_branch));
        check_value("is_return", 128'(got.is_return), 128'(exp.is_return));
        check_value("is_valid", 128'(got.is_valid), 128'(exp.is_valid));
    endtask

    // quadrants 0 to 2, retried until the encoding is a legal one
    function automatic logic [15:0] legal_instr();
        logic [15:0] pick;
        logic [15:0] cand;
        decoded_t    d;
        pick = 16'h0001;
        for (int i = 0; i < 64; i++) begin
            cand      = 16'($urandom());
            cand[1:0] = 2'($urandom_range(0, 2));
            d         = decode_ref(32'd0, cand);
            if (d.is_valid) begin
                pick = cand;
                break;
            end
        end
        return pick;
    endfunction

    task automatic send_instr(input logic [15:0] ins, input bit gaps);
        int wait_cycles;
        if (gaps && $urandom_range(0, 2) == 0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid      <= 1'b1;
        in_data.pc    <= pc_next;
        in_data.instr <= ins;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!in_ready && wait_cycles < 100);
        if (in_ready) begin
            expect_record(pc_next, ins);
            in_cnt++;
        end else begin
            errors++;
            $display("input at pc 0x%0h was not accepted within 100 cycles", pc_next);
        end
        pc_next = pc_next + 32'd2;
    endtask

    task automatic drain_and_report(input string name, input int mark);
        int wait_cycles;
        in_valid   <= 1'b0;
        ready_high <= 1'b1;
        streaming  <= 1'b0;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (expected_q.size() != 0 && wait_cycles < 100);
        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d records never came out of the decoder", expected_q.size());
        end
        check_value("output count", 128'(out_cnt), 128'(in_cnt));
        $display("%-12s done, %0d errors", name, errors - mark);
    endtask

    always @(posedge clk) begin
        out_ready <= ready_high ? 1'b1 : ($urandom_range(0, 1) == 1);
    end

    // scoreboard
    always @(posedge clk) begin
        decoded_t expected;
        if (arst_n && out_valid && out_ready) begin
            out_cnt++;
            if (expected_q.size() == 0) begin
                errors++;
                $display("record for pc 0x%0h came out with none expected", out_data.pc);
            end else begin
                expected = expected_q.pop_front();
                compare_record(out_data, expected);
            end
        end
        if (streaming && stream_seen && !in_ready) begin
            errors++;
            $display("in_ready dropped while streaming");
        end
        stream_seen = streaming && (stream_seen || out_valid);
    end

    initial begin
        int mark;
        void'($urandom(62));
        arst_n     <= 1'b0;
        in_valid   <= 1'b0;
        in_data    <= '0;
        out_ready  <= 1'b0;
        ready_high <= 1'b0;
        streaming  <= 1'b0;

        @(posedge clk);
        @(posedge clk);
        check_value("out_valid", 128'(out_valid), 128'(1'b0));
        check_value("in_ready", 128'(in_ready), 128'(1'b1));
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("out_valid", 128'(out_valid), 128'(1'b0));
        check_value("in_ready", 128'(in_ready), 128'(1'b1));
        $display("%-12s done, %0d errors", "reset", errors);

        mark = errors;
        repeat (300) begin
            if ($urandom_range(0, 9) < 7) begin
                send_instr(legal_instr(), 1'b1);
            end else begin
                send_instr(16'($urandom()), 1'b1);
            end
        end
        drain_and_report("random mix", mark);

        mark = errors;
        ready_high <= 1'b0;
        repeat (4) begin
            send_instr({14'($urandom()), 2'b11}, 1'b1);
            send_instr({3'b001, 11'($urandom()), 2'b00}, 1'b1);
            send_instr({3'b101, 11'($urandom()), 2'b00}, 1'b1);
            send_instr({3'b100, 11'($urandom()), 2'b00}, 1'b1);
            send_instr({3'b001, 11'($urandom()), 2'b10}, 1'b1);
            send_instr({3'b101, 11'($urandom()), 2'b10}, 1'b1);
            send_instr(16'h9002, 1'b1);
            send_instr(16'h6001, 1'b1);
        end
        drain_and_report("reserved", mark);

        // j, jal, jr, jalr, beqz, bnez, then jr ra
        mark = errors;
        ready_high <= 1'b0;
        repeat (8) begin
            send_instr({3'b101, 11'($urandom()), 2'b01}, 1'b1);
            send_instr({3'b001, 11'($urandom()), 2'b01}, 1'b1);
            send_instr({4'b1000, 5'($urandom_range(1, 31)), 7'b0000010}, 1'b1);
            send_instr({4'b1001, 5'($urandom_range(1, 31)), 7'b0000010}, 1'b1);
            send_instr({3'b110, 11'($urandom()), 2'b01}, 1'b1);
            send_instr({3'b111, 11'($urandom()), 2'b01}, 1'b1);
            send_instr(16'h8082, 1'b1);
        end
        drain_and_report("branches", mark);

        mark = errors;
        ready_high <= 1'b1;
        streaming  <= 1'b1;
        repeat (100) begin
            send_instr(legal_instr(), 1'b0);
        end
        drain_and_report("streaming", mark);

        $display("checks %0d, records %0d, errors %0d", checks, out_cnt, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+testbench
source/rvc_pkg.sv
source/rvc_fetch_reg.sv
source/rvc_op_decode.sv
source/rvc_imm_gen.sv
source/rvc_issue_reg.sv
source/rvc_decoder_top.sv
testbench/rvc_decoder_props.sv
testbench/tb_rvc_decoder.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rvc_decoder
RTL_TOP   ?= rvc_decoder_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RTL_SRCS  := $(shell grep '^source/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
